// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0 --timescale 1ns/10ps
TOP       = opn_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Finished with no errors

SOURCES = $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass message shows up as its own line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/opn_bus_pkg.sv ====
package opn_bus_pkg;

    // Host pins after decode
    // addr[0] picks address or data phase, addr[1] picks the port
    typedef struct packed {
        logic [1:0] addr;
        logic [7:0] din;
        logic       write;   // cs_n and wr_n both low
    } cpu_bus_t;

    // Register number held between the two bus phases
    typedef logic [7:0] reg_addr_t;

endpackage

// ==== design/opn_consts.svh ====
`ifndef OPN_CONSTS_SVH
`define OPN_CONSTS_SVH

// Timer registers, lower port only
`define OPN_REG_TA_HI    8'h24  // Timer A bits 9..2
`define OPN_REG_TA_LO    8'h25  // Timer A bits 1..0
`define OPN_REG_TB       8'h26
`define OPN_REG_CTL      8'h27

// Bit positions inside register 0x27
`define OPN_CTL_LOAD_A   0
`define OPN_CTL_LOAD_B   1
`define OPN_CTL_IRQ_A    2
`define OPN_CTL_IRQ_B    3
`define OPN_CTL_CLR_A    4
`define OPN_CTL_CLR_B    5

`define OPN_TICK_DIV     24     // Clocks per sample, one per operator slot
`define OPN_TB_PRESCALE  16     // Timer B steps once every 16 ticks
`define OPN_BUSY_CYCLES  32

// Status byte layout
`define OPN_ST_BUSY      7
`define OPN_ST_FLAG_A    0
`define OPN_ST_FLAG_B    1

`endif

// ==== design/opn_flags.sv ====
`timescale 1ns/10ps
`include "opn_consts.svh"

module opn_flags (
    input  logic                      zero,
    input  logic                      rst_n,
    input  opn_timer_pkg::timer_ovf_t ovf,
    input  opn_timer_pkg::timer_ctl_t ctl,
    input  logic                      busy,
    output logic [7:0]                dout,
    output logic                      irq_n
);
    logic flag_a;
    logic flag_b;

    // Clear has priority over a same-cycle overflow
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            flag_a <= 1'b0;
        end else if (ctl.clr_a) begin
            flag_a <= 1'b0;
        end else if (ovf.ovf_a && ctl.irq_en_a) begin
            flag_a <= 1'b1;
        end
    end

    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            flag_b <= 1'b0;
        end else if (ctl.clr_b) begin
            flag_b <= 1'b0;
        end else if (ovf.ovf_b && ctl.irq_en_b) begin
            flag_b <= 1'b1;
        end
    end

    // Status byte, unused bits read as zero
    always_comb begin
        dout                 = '0;
        dout[`OPN_ST_BUSY]   = busy;
        dout[`OPN_ST_FLAG_A] = flag_a;
        dout[`OPN_ST_FLAG_B] = flag_b;
    end

    assign irq_n = !(flag_a || flag_b);   // Open drain style, low while pending

endmodule

// ==== design/opn_regs.sv ====
`timescale 1ns/10ps
`include "opn_consts.svh"

module opn_regs (
    input  logic                      zero,
    input  logic                      rst_n,
    input  opn_bus_pkg::cpu_bus_t     bus,
    output opn_timer_pkg::timer_a_t   value_a,
    output opn_timer_pkg::timer_b_t   value_b,
    output opn_timer_pkg::timer_ctl_t ctl,
    output logic                      tick,
    output logic                      busy
);
    import opn_bus_pkg::*;

    localparam int TICK_W = $clog2(`OPN_TICK_DIV);
    localparam int BUSY_W = $clog2(`OPN_BUSY_CYCLES + 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`OPN_TICK_DIV - 1);

    reg_addr_t         reg_num;
    logic              reg_hi;     // Register number came through the upper port
    logic              addr_wr;
    logic              data_wr;
    logic              timer_wr;
    logic              tick_wrap;
    logic [TICK_W-1:0] tick_cnt;
    logic [BUSY_W-1:0] busy_cnt;

    assign addr_wr   = bus.write && !bus.addr[0];
    assign data_wr   = bus.write && bus.addr[0];
    assign timer_wr  = data_wr && !reg_hi;       // Timers sit in the lower port
    assign tick_wrap = (tick_cnt == TICK_LAST);

    // Address phase
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            reg_num <= '0;
            reg_hi  <= 1'b0;
        end else if (addr_wr) begin
            reg_num <= bus.din;
            reg_hi  <= bus.addr[1];
        end
    end

    // Timer reload values
    always_ff @(posedge zero) begin
        if (timer_wr) begin
            case (reg_num)
                `OPN_REG_TA_HI: value_a[9:2] <= bus.din;
                `OPN_REG_TA_LO: value_a[1:0] <= bus.din[1:0];
                `OPN_REG_TB:    value_b      <= bus.din;
                default: ;                   // Not a timer register
            endcase
        end
    end

    // Timer control, 0x27
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            ctl <= '0;
        end else begin
            ctl.clr_a <= 1'b0;
            ctl.clr_b <= 1'b0;
            if (timer_wr && reg_num == `OPN_REG_CTL) begin
                ctl.load_a   <= bus.din[`OPN_CTL_LOAD_A];
                ctl.load_b   <= bus.din[`OPN_CTL_LOAD_B];
                ctl.irq_en_a <= bus.din[`OPN_CTL_IRQ_A];
                ctl.irq_en_b <= bus.din[`OPN_CTL_IRQ_B];
                ctl.clr_a    <= bus.din[`OPN_CTL_CLR_A];   // Pulse, not stored
                ctl.clr_b    <= bus.din[`OPN_CTL_CLR_B];
            end
        end
    end

    // Sample tick, stands in for the slot sequencer
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= tick_wrap;
            if (tick_wrap) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // Busy window
    // Every data write restarts it, whichever port or register
    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(`OPN_BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

endmodule

// ==== design/opn_timer.sv ====
`timescale 1ns/10ps

module opn_timer #(
    parameter type count_t  = opn_timer_pkg::timer_a_t,
    parameter int  PRESCALE = 1
) (
    input  logic   zero,
    input  logic   rst_n,
    input  logic   tick,
    input  logic   load,
    input  count_t value,
    output logic   ovf
);
    localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(PRESCALE - 1);

    count_t           cnt;
    logic [PRE_W-1:0] pre_cnt;
    logic             load_q;   // Load level one clock ago
    logic             armed;    // Load seen, waiting for a tick
    logic             run;
    logic             start;
    logic             step;

    assign start = load && armed && tick;
    assign step  = load && run && tick && (pre_cnt == PRE_LAST);

    always_ff @(posedge zero or negedge rst_n) begin
        if (!rst_n) begin
            load_q  <= 1'b0;
            armed   <= 1'b0;
            run     <= 1'b0;
            pre_cnt <= '0;
            ovf     <= 1'b0;
        end else begin
            load_q <= load;
            ovf    <= step && (&cnt);      // Step out of the all-ones state
            if (!load) begin
                armed <= 1'b0;                 // Load low stops the count
                run   <= 1'b0;
            end else if (!load_q) begin
                armed <= 1'b1;
            end else if (start) begin
                armed <= 1'b0;
                run   <= 1'b1;
            end
            // Prescaler phase starts at the copy so every period is whole
            if (start) begin
                pre_cnt <= '0;
            end else if (run && tick) begin
                pre_cnt <= (pre_cnt == PRE_LAST) ? '0 : pre_cnt + 1'b1;
            end
        end
    end

    // Counter, reloads on overflow and keeps going
    always_ff @(posedge zero) begin
        if (start) begin
            cnt <= value;
        end else if (step) begin
            cnt <= (&cnt) ? value : cnt + 1'b1;
        end
    end

endmodule

// ==== design/opn_timer_pkg.sv ====
package opn_timer_pkg;

    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;

    // Same bit order as register 0x27, MSB first
    // Load and IRQ enable are levels, clear bits last one clock
    typedef struct packed {
        logic clr_b;
        logic clr_a;
        logic irq_en_b;
        logic irq_en_a;
        logic load_b;
        logic load_a;
    } timer_ctl_t;

    // Single clock overflow strobes from the two timers
    typedef struct packed {
        logic ovf_b;
        logic ovf_a;
    } timer_ovf_t;

endpackage

// ==== design/opn_timer_top.sv ====
`timescale 1ns/10ps
`include "opn_consts.svh"

module opn_timer_top (
    input  logic       zero,
    input  logic       rst_n,
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic [1:0] addr,
    input  logic [7:0] din,
    output logic [7:0] dout,
    output logic       irq_n
);
    import opn_bus_pkg::*;
    import opn_timer_pkg::*;

    cpu_bus_t   bus;
    timer_a_t   value_a;
    timer_b_t   value_b;
    timer_ctl_t ctl;
    timer_ovf_t ovf;
    logic       tick;
    logic       busy;
    logic       ovf_a;
    logic       ovf_b;

    assign bus = '{addr: addr, din: din, write: !cs_n && !wr_n};
    assign ovf = '{ovf_b: ovf_b, ovf_a: ovf_a};

    opn_regs u_regs (
        .zero    ( zero    ),
        .rst_n   ( rst_n   ),
        .bus     ( bus     ),
        .value_a ( value_a ),
        .value_b ( value_b ),
        .ctl     ( ctl     ),
        .tick    ( tick    ),
        .busy    ( busy    )
    );

    opn_timer #(.count_t(timer_a_t), .PRESCALE(1)) u_timer_a (
        .zero  ( zero       ),
        .rst_n ( rst_n      ),
        .tick  ( tick       ),
        .load  ( ctl.load_a ),
        .value ( value_a    ),
        .ovf   ( ovf_a      )
    );

    opn_timer #(.count_t(timer_b_t), .PRESCALE(`OPN_TB_PRESCALE)) u_timer_b (
        .zero  ( zero       ),
        .rst_n ( rst_n      ),
        .tick  ( tick       ),
        .load  ( ctl.load_b ),
        .value ( value_b    ),
        .ovf   ( ovf_b      )
    );

    opn_flags u_flags (
        .zero  ( zero  ),
        .rst_n ( rst_n ),
        .ovf   ( ovf   ),
        .ctl   ( ctl   ),
        .busy  ( busy  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

endmodule

// ==== tb/opn_tb.sv ====
`timescale 1ns/10ps
`include "opn_consts.svh"

module opn_tb;
    import opn_bus_pkg::*;
    import opn_timer_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int TICK         = `OPN_TICK_DIV;   // Clocks per timer tick

    localparam logic [7:0] BUSY_BIT = 8'(1 << `OPN_ST_BUSY);
    localparam logic [7:0] FLAG_A   = 8'(1 << `OPN_ST_FLAG_A);
    localparam logic [7:0] FLAG_B   = 8'(1 << `OPN_ST_FLAG_B);
    localparam logic [7:0] FLAGS    = FLAG_A | FLAG_B;
    localparam reg_addr_t  UNMAPPED = 8'h28;      // Outside the timer block

    // One step of the test table
    typedef struct packed {
        int         test;
        logic       wr;          // Row starts with a register write
        reg_addr_t  reg_num;
        logic [7:0] data;
        int         cycles;      // Clocks to wait before the check
        logic [7:0] mask;
        logic [7:0] exp_dout;
        logic       exp_irq_n;
    } row_t;

    logic       zero;
    logic       rst_n;
    logic       cs_n;
    logic       wr_n;
    logic [1:0] addr;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq_n;

    row_t        rows[$];
    string       test_name[1:6];
    logic [15:0] lfsr;
    timer_a_t    a_val;
    timer_b_t    b_val;
    bit          table_ready;
    int          wait_sum     = 0;
    int          errors       = 0;
    int          checks       = 0;
    int          test_errors  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    opn_timer_top u_opn_timer_top (
        .zero  ( zero  ),
        .rst_n ( rst_n ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .addr  ( addr  ),
        .din   ( din   ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    always #(CLK_PERIOD / 2) zero = ~zero;

    // Galois form with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits[k] = lfsr[0];
            lfsr    = lfsr_next(lfsr);   // One step per bit
        end
    endtask

    function automatic logic [7:0] ctl_bit(input int pos);
        return 8'(1 << pos);
    endfunction

    task automatic add_row(input int test, input logic wr, input reg_addr_t num,
                           input logic [7:0] data, input int cycles, input logic [7:0] mask,
                           input logic [7:0] exp_dout, input logic exp_irq_n);
        row_t r;
        r = '{test, wr, num, data, cycles, mask, exp_dout, exp_irq_n};
        rows.push_back(r);
        wait_sum += cycles;
    endtask

    task automatic build_table();
        logic [7:0] rnd;
        logic [7:0] ctl_a_on;
        logic [7:0] ctl_b_on;
        logic [7:0] ctl_loads;
        logic [7:0] ctl_irqs;
        int         pa;
        int         pb;
        int         pmax;
        int         long_wait;
        take_bits(3, rnd);
        a_val = 10'(1016 + int'(rnd[2:0]));
        take_bits(1, rnd);
        b_val = 8'(254 + int'(rnd[0]));
        pa    = 1024 - int'(a_val);                         // Periods in ticks
        pb    = (256 - int'(b_val)) * `OPN_TB_PRESCALE;
        pmax  = (pa > pb) ? pa : pb;
        long_wait = (2 * pmax + 2) * TICK;                  // Two periods and margin
        ctl_a_on  = ctl_bit(`OPN_CTL_LOAD_A) | ctl_bit(`OPN_CTL_IRQ_A);
        ctl_b_on  = ctl_bit(`OPN_CTL_LOAD_B) | ctl_bit(`OPN_CTL_IRQ_B);
        ctl_loads = ctl_bit(`OPN_CTL_LOAD_A) | ctl_bit(`OPN_CTL_LOAD_B);
        ctl_irqs  = ctl_bit(`OPN_CTL_IRQ_A) | ctl_bit(`OPN_CTL_IRQ_B);

        add_row(1, 1'b0, 8'h00, 8'h00, 0, 8'hFF, 8'h00, 1'b1);
        add_row(2, 1'b1, `OPN_REG_TA_HI, a_val[9:2], 0, BUSY_BIT, BUSY_BIT, 1'b1);
        add_row(2, 1'b0, 8'h00, 8'h00, `OPN_BUSY_CYCLES - 1, BUSY_BIT, BUSY_BIT, 1'b1);
        add_row(2, 1'b0, 8'h00, 8'h00, 1, BUSY_BIT, 8'h00, 1'b1);
        add_row(3, 1'b1, `OPN_REG_TA_LO, {6'd0, a_val[1:0]}, 0, BUSY_BIT | FLAGS, BUSY_BIT,
                1'b1);
        add_row(3, 1'b1, `OPN_REG_CTL, ctl_a_on, (pa - 1) * TICK, FLAGS, 8'h00, 1'b1);
        add_row(3, 1'b0, 8'h00, 8'h00, 3 * TICK, FLAGS, FLAG_A, 1'b0);
        add_row(4, 1'b1, `OPN_REG_CTL, ctl_bit(`OPN_CTL_CLR_A), 1, FLAGS, 8'h00, 1'b1);
        add_row(4, 1'b1, `OPN_REG_TB, b_val, 0, BUSY_BIT | FLAGS, BUSY_BIT, 1'b1);
        add_row(4, 1'b1, `OPN_REG_CTL, ctl_b_on, (pb - 1) * TICK, FLAGS, 8'h00, 1'b1);
        add_row(4, 1'b0, 8'h00, 8'h00, 3 * TICK, FLAGS, FLAG_B, 1'b0);
        // Loads on, IRQ enables off, B flag cleared on the way
        add_row(5, 1'b1, `OPN_REG_CTL, ctl_loads | ctl_bit(`OPN_CTL_CLR_B), long_wait,
                FLAGS, 8'h00, 1'b1);
        add_row(5, 1'b1, `OPN_REG_CTL, 8'h00, 1, BUSY_BIT | FLAGS, BUSY_BIT, 1'b1);
        add_row(5, 1'b1, `OPN_REG_CTL, ctl_irqs, long_wait, FLAGS, 8'h00, 1'b1);
        // Would start both timers if it hit 0x27
        add_row(6, 1'b1, UNMAPPED, ctl_loads | ctl_irqs, 0, BUSY_BIT | FLAGS, BUSY_BIT, 1'b1);
        add_row(6, 1'b0, 8'h00, 8'h00, long_wait, 8'hFF, 8'h00, 1'b1);
    endtask

    // Address phase, data phase, then bus idle
    task automatic bus_write(input reg_addr_t num, input logic [7:0] value);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'b00;
        din  = num;
        @(negedge zero);
        addr = 2'b01;
        din  = value;
        @(negedge zero);
        cs_n = 1'b1;
        wr_n = 1'b1;
        addr = 2'b00;
        din  = 8'h00;
    endtask

    task automatic check_row(input row_t r);
        checks += 2;
        assert ((dout & r.mask) == r.exp_dout) else begin
            $display("[FAIL] test %0d dout: got %02h, expected %02h under mask %02h",
                     r.test, dout & r.mask, r.exp_dout, r.mask);
            errors++;
            test_errors++;
        end
        assert (irq_n == r.exp_irq_n) else begin
            $display("[FAIL] test %0d irq_n: got %h, expected %h", r.test, irq_n, r.exp_irq_n);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int test);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", test, test_name[test]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test, test_name[test], test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        zero  = 1'b0;
        rst_n = 1'b0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        addr  = 2'b00;
        din   = 8'h00;
        lfsr  = 16'd6;
        test_name[1] = "reset state";
        test_name[2] = "busy window";
        test_name[3] = "timer A flag";
        test_name[4] = "flag clear and timer B";
        test_name[5] = "no flag without enable or load";
        test_name[6] = "unmapped register write";
        build_table();
        table_ready = 1'b1;
        $display("timer A = %03h, timer B = %02h", a_val, b_val);
        repeat (RESET_CYCLES) @(negedge zero);
        rst_n = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].wr) begin
                bus_write(rows[i].reg_num, rows[i].data);
            end
            repeat (rows[i].cycles) @(negedge zero);
            check_row(rows[i]);
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                report_test(rows[i].test);
            end
        end

        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        wait (table_ready);
        #((2 * wait_sum + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the test table did not complete in the allowed time");
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/opn_bus_pkg.sv
design/opn_timer_pkg.sv
design/opn_regs.sv
design/opn_timer.sv
design/opn_flags.sv
design/opn_timer_top.sv
tb/opn_tb.sv
